// ==== include/fp_cvt_params.svh ====
`ifndef FP_CVT_PARAMS_SVH
`define FP_CVT_PARAMS_SVH

// data word width of operands and results
`define FP_CVT_WIDTH 32

// exception flags in RISC-V order NV DZ OF UF NX
`define FP_CVT_NFLAGS 5

// completion counter width, wraps on overflow
`define FP_CVT_CNT_WIDTH 16

`endif

// ==== design/lzc_wire.sv ====
package lzc_wire;

    // leading-zero count of a 32-bit word
    // an all-zero word is reported separately by the counter
    typedef logic [4:0] lzc_count_t;

endpackage

// ==== design/fp_wire.sv ====
`include "fp_cvt_params.svh"

package fp_wire;

    typedef enum logic [1:0] {
        CVT_F2I = 2'd0,  // binary32 to signed int
        CVT_F2U = 2'd1,  // binary32 to unsigned int
        CVT_I2F = 2'd2,  // signed int to binary32
        CVT_U2F = 2'd3   // unsigned int to binary32
    } cvt_op_t;

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } rnd_mode_t;

    // nv is the top bit and nx the bottom one
    typedef logic [`FP_CVT_NFLAGS-1:0] fp_flags_t;

    localparam int FLAG_NV = 4;
    localparam int FLAG_NX = 0;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } fp_single_t;

    typedef union packed {
        logic [`FP_CVT_WIDTH-1:0] word;  // integer view
        fp_single_t               fp;    // binary32 view
    } fp_operand_u;

endpackage

// ==== design/lzc_32.sv ====
`timescale 1ns/100ps

module lzc_32
    import lzc_wire::*;
(
    input  logic [31:0] value_i,
    output lzc_count_t  count_o,
    output logic        zero_o
);

    logic       node_zero [6][32];
    lzc_count_t node_cnt  [6][32];

    always_comb begin
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 32; i++) begin
                node_zero[k][i] = 1'b0;
                node_cnt[k][i]  = '0;
            end
        end
        for (int i = 0; i < 32; i++) begin
            node_zero[0][i] = ~value_i[31 - i];  // leaf 0 is the msb
        end
        // each level merges a left and a right half of twice the size below
        for (int k = 1; k < 6; k++) begin
            for (int i = 0; i < (32 >> k); i++) begin
                node_zero[k][i] = node_zero[k-1][2*i] & node_zero[k-1][2*i+1];
                if (node_zero[k-1][2*i]) begin
                    node_cnt[k][i] = lzc_count_t'(1 << (k - 1)) + node_cnt[k-1][2*i+1];
                end else begin
                    node_cnt[k][i] = node_cnt[k-1][2*i];
                end
            end
        end
    end

    assign count_o = node_cnt[5][0];
    assign zero_o  = node_zero[5][0];

endmodule

// ==== design/fp_cvt.sv ====
`timescale 1ns/100ps
`include "fp_cvt_params.svh"

module fp_cvt
    import lzc_wire::*;
    import fp_wire::*;
(
    input  fp_operand_u              operand_i,
    input  cvt_op_t                  op_i,
    input  rnd_mode_t                rm_i,
    input  lzc_count_t               lzc_count_i,
    output logic [`FP_CVT_WIDTH-1:0] lzc_value_o,
    output logic [`FP_CVT_WIDTH-1:0] int_result_o,
    output fp_flags_t                int_flags_o,
    output logic                     sign_o,
    output logic [9:0]               exponent_o,
    output logic [23:0]              significand_o,
    output logic [2:0]               grs_o,
    output logic                     zero_o,
    output rnd_mode_t                rm_o
);

    logic                     unsigned_op;
    logic                     f_sign;
    logic                     f_nan;
    logic [23:0]              f_mant;
    logic [9:0]               f_unbiased;
    logic                     f_oor;
    logic [57:0]              f_shifted;
    logic [31:0]              f_int;
    logic [2:0]               f_grs;
    logic                     f_inexact;
    logic                     f_rnd;
    logic [31:0]              f_mag;
    logic                     f_invalid;
    logic                     i_sign;
    logic [`FP_CVT_WIDTH-1:0] i_mag;
    logic [`FP_CVT_WIDTH-1:0] i_norm;

    assign unsigned_op = op_i[0];  // ops 1 and 3 are the unsigned forms

    always_comb begin
        f_sign     = operand_i.fp.sign;
        f_nan      = (operand_i.fp.exponent == 8'hFF) & (operand_i.fp.fraction != '0);
        f_mant     = {operand_i.fp.exponent != 8'h00, operand_i.fp.fraction};
        f_unbiased = {2'b00, operand_i.fp.exponent} - 10'd127;
        f_oor      = 1'b0;
        f_shifted  = '0;
        // bit 26 of the shifted word carries weight one
        if ($signed(f_unbiased) > 31) begin
            f_oor = 1'b1;  // also catches infinity and nan
        end else if ($signed(f_unbiased) >= -1) begin
            f_shifted = {32'h0, f_mant, 2'b00} << (f_unbiased[5:0] + 6'd1);
        end else begin
            f_shifted[0] = |f_mant;  // below one half only the sticky bit survives
        end

        f_int     = f_shifted[57:26];
        f_grs     = {f_shifted[25], f_shifted[24], |f_shifted[23:0]};
        f_inexact = |f_grs;

        case (rm_i)
            RM_RNE:  f_rnd = f_grs[2] & ((|f_grs[1:0]) | f_int[0]);
            RM_RDN:  f_rnd = f_sign & f_inexact;
            RM_RUP:  f_rnd = ~f_sign & f_inexact;
            RM_RMM:  f_rnd = f_grs[2];
            default: f_rnd = 1'b0;  // rtz truncates the magnitude
        endcase

        f_mag = f_int + 32'(f_rnd);  // the sum stays below 2^32 for exponents up to 31

        if (unsigned_op) begin
            f_invalid = f_nan | f_oor | (f_sign & (f_mag != '0));
        end else begin
            f_invalid = f_nan | f_oor
                      | (f_sign ? (f_mag[31] & (|f_mag[30:0])) : f_mag[31]);
        end

        int_flags_o = '0;
        if (f_invalid) begin
            int_flags_o[FLAG_NV] = 1'b1;
            if (f_nan | ~f_sign) begin
                int_result_o = unsigned_op ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
            end else begin
                int_result_o = unsigned_op ? 32'h0000_0000 : 32'h8000_0000;
            end
        end else begin
            // an unsigned negative lands here only when it rounded to zero
            int_flags_o[FLAG_NX] = f_inexact;
            int_result_o         = f_sign ? -f_mag : f_mag;
        end
    end

    // integer to float, normalized here and rounded in fp_rnd
    assign i_sign      = ~unsigned_op & operand_i.word[31];
    assign i_mag       = i_sign ? -operand_i.word : operand_i.word;
    assign lzc_value_o = i_mag;
    assign i_norm      = i_mag << lzc_count_i;

    assign sign_o        = i_sign;
    assign exponent_o    = 10'd158 - {5'b00000, lzc_count_i};  // bias plus 31
    assign significand_o = i_norm[31:8];
    assign grs_o         = {i_norm[7], i_norm[6], |i_norm[5:0]};
    assign zero_o        = (i_mag == '0);
    assign rm_o          = rm_i;

endmodule

// ==== design/fp_rnd.sv ====
`timescale 1ns/100ps

module fp_rnd
    import fp_wire::*;
(
    input  logic        sign_i,
    input  logic [9:0]  exponent_i,
    input  logic [23:0] significand_i,
    input  logic [2:0]  grs_i,
    input  logic        zero_i,
    input  rnd_mode_t   rm_i,
    output fp_operand_u result_o,
    output fp_flags_t   flags_o
);

    logic        inexact;
    logic        inc;
    logic [24:0] sum;
    logic [9:0]  exponent;

    assign inexact = |grs_i;

    always_comb begin
        case (rm_i)
            RM_RNE:  inc = grs_i[2] & ((|grs_i[1:0]) | significand_i[0]);
            RM_RDN:  inc = sign_i & inexact;
            RM_RUP:  inc = ~sign_i & inexact;
            RM_RMM:  inc = grs_i[2];
            default: inc = 1'b0;
        endcase
    end

    assign sum      = {1'b0, significand_i} + 25'(inc);
    assign exponent = exponent_i + 10'(sum[24]);  // carry out renormalizes to 1.0

    always_comb begin
        flags_o = '0;
        if (zero_i) begin
            result_o = '0;  // integer zero always gives +0
        end else begin
            result_o.fp.sign     = sign_i;
            result_o.fp.exponent = exponent[7:0];
            result_o.fp.fraction = sum[22:0];  // a carry out leaves all fraction bits zero
            flags_o[FLAG_NX]     = inexact;
        end
    end

endmodule

// ==== design/fp_cvt_ctrl.sv ====
`timescale 1ns/100ps

module fp_cvt_ctrl (
    input  logic clock_i,
    input  logic rst_i,
    input  logic start_i,
    output logic load_o,
    output logic commit_o,
    output logic busy_o,
    output logic valid_o
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        EXEC = 2'd1,
        DONE = 2'd2
    } state_t;

    state_t state;
    state_t state_next;

    // a start in the valid cycle is taken straight away
    assign load_o = start_i & (state != EXEC);

    always_comb begin
        case (state)
            EXEC:    state_next = DONE;
            default: state_next = load_o ? EXEC : IDLE;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign commit_o = (state == EXEC);
    assign busy_o   = (state == EXEC);
    assign valid_o  = (state == DONE);  // done is entered only from exec, one cycle after commit

endmodule

// ==== design/fp_cvt_status.sv ====
`timescale 1ns/100ps
`include "fp_cvt_params.svh"

module fp_cvt_status
    import fp_wire::*;
(
    input  logic                         clock_i,
    input  logic                         rst_i,
    input  logic                         clear_i,
    input  logic                         commit_i,
    input  fp_flags_t                    flags_i,
    output fp_flags_t                    acc_flags_o,
    output logic [`FP_CVT_CNT_WIDTH-1:0] count_o
);

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            acc_flags_o <= '0;
            count_o     <= '0;
        end else if (clear_i) begin
            acc_flags_o <= '0;  // clear drops the flags of a same-cycle completion
            count_o     <= `FP_CVT_CNT_WIDTH'(commit_i);
        end else if (commit_i) begin
            acc_flags_o <= acc_flags_o | flags_i;
            count_o     <= count_o + 1'b1;
        end
    end

endmodule

// ==== design/fp_cvt_unit.sv ====
`timescale 1ns/100ps
`include "fp_cvt_params.svh"

module fp_cvt_unit
    import lzc_wire::*;
    import fp_wire::*;
(
    input  logic                         clock_i,
    input  logic                         rst_i,
    input  logic                         start_i,
    input  cvt_op_t                      op_i,
    input  rnd_mode_t                    rm_i,
    input  fp_operand_u                  operand_i,
    input  logic                         clear_i,
    output logic                         busy_o,
    output logic                         valid_o,
    output fp_operand_u                  result_o,
    output fp_flags_t                    flags_o,
    output fp_flags_t                    acc_flags_o,
    output logic [`FP_CVT_CNT_WIDTH-1:0] count_o
);

    logic                     load;
    logic                     commit;
    cvt_op_t                  op_q;
    rnd_mode_t                rm_q;
    fp_operand_u              operand_q;
    logic [`FP_CVT_WIDTH-1:0] lzc_value;
    lzc_count_t               lzc_count;
    logic [`FP_CVT_WIDTH-1:0] int_result;
    fp_flags_t                int_flags;
    logic                     rnd_sign;
    logic [9:0]               rnd_exponent;
    logic [23:0]              rnd_significand;
    logic [2:0]               rnd_grs;
    logic                     rnd_zero;
    rnd_mode_t                rnd_rm;
    fp_operand_u              rnd_result;
    fp_flags_t                rnd_flags;

    fp_cvt_ctrl fp_cvt_ctrl_i (
        .clock_i  (clock_i),
        .rst_i    (rst_i),
        .start_i  (start_i),
        .load_o   (load),
        .commit_o (commit),
        .busy_o   (busy_o),
        .valid_o  (valid_o)
    );

    always_ff @(posedge clock_i) begin
        if (load) begin
            op_q      <= op_i;
            rm_q      <= rm_i;
            operand_q <= operand_i;
        end
    end

    lzc_32 lzc_32_i (
        .value_i (lzc_value),
        .count_o (lzc_count),
        .zero_o  ()  // the converter detects zero on its own magnitude
    );

    fp_cvt fp_cvt_i (
        .operand_i     (operand_q),
        .op_i          (op_q),
        .rm_i          (rm_q),
        .lzc_count_i   (lzc_count),
        .lzc_value_o   (lzc_value),
        .int_result_o  (int_result),
        .int_flags_o   (int_flags),
        .sign_o        (rnd_sign),
        .exponent_o    (rnd_exponent),
        .significand_o (rnd_significand),
        .grs_o         (rnd_grs),
        .zero_o        (rnd_zero),
        .rm_o          (rnd_rm)
    );

    fp_rnd fp_rnd_i (
        .sign_i        (rnd_sign),
        .exponent_i    (rnd_exponent),
        .significand_i (rnd_significand),
        .grs_i         (rnd_grs),
        .zero_i        (rnd_zero),
        .rm_i          (rnd_rm),
        .result_o      (rnd_result),
        .flags_o       (rnd_flags)
    );

    // op bit 1 set means integer to float
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            result_o <= '0;
            flags_o  <= '0;
        end else if (commit) begin
            result_o <= op_q[1] ? rnd_result : fp_operand_u'(int_result);
            flags_o  <= op_q[1] ? rnd_flags : int_flags;
        end
    end

    fp_cvt_status fp_cvt_status_i (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .clear_i     (clear_i),
        .commit_i    (commit),
        .flags_i     (op_q[1] ? rnd_flags : int_flags),
        .acc_flags_o (acc_flags_o),
        .count_o     (count_o)
    );

endmodule

// ==== bench/fp_cvt_model.svh ====
`ifndef FP_CVT_MODEL_SVH
`define FP_CVT_MODEL_SVH

// ieee rounding decision from the discarded part of an exact value
function automatic logic round_increment(input rnd_mode_t rnd, input logic neg,
                                         input logic lsb, input logic above_half,
                                         input logic at_half, input logic inexact);
    case (rnd)
        RM_RNE:  return above_half | (at_half & lsb);
        RM_RDN:  return neg & inexact;
        RM_RUP:  return ~neg & inexact;
        RM_RMM:  return above_half | at_half;
        default: return 1'b0;
    endcase
endfunction

// value is m * 2^e exactly, split into integer part q and remainder rem
function automatic void float_to_int_expected(input fp_operand_u a, input logic is_unsigned,
                                              input rnd_mode_t rnd, output logic [31:0] res,
                                              output fp_flags_t fl);
    logic        neg;
    logic        nan;
    logic        huge;
    logic [79:0] m, q, rem, half, mag, limit;
    int          e;
    neg  = a.fp.sign;
    nan  = (a.fp.exponent == 8'hFF) && (a.fp.fraction != '0);
    huge = (a.fp.exponent == 8'hFF);
    m    = (a.fp.exponent == 8'h00) ? {57'h0, a.fp.fraction} : {56'h0, 1'b1, a.fp.fraction};
    e    = (a.fp.exponent == 8'h00) ? -149 : int'(a.fp.exponent) - 150;
    q    = '0;
    rem  = '0;
    half = 80'h1 << 40;
    if (e > 40) begin
        huge = 1'b1;
    end else if (e >= 0) begin
        q = m << e;
    end else if (e < -30) begin
        rem = {79'h0, m != '0};  // far below one half
    end else begin
        q    = m >> (-e);
        rem  = m & ((80'h1 << (-e)) - 1);
        half = 80'h1 << (-e - 1);
    end
    mag = q + {79'h0, round_increment(rnd, neg, q[0], rem > half, rem == half, rem != '0)};
    if (is_unsigned) begin
        limit = neg ? 80'h0 : 80'hFFFF_FFFF;
    end else begin
        limit = neg ? 80'h8000_0000 : 80'h7FFF_FFFF;
    end
    fl = '0;
    if (nan || huge || mag > limit) begin
        fl[FLAG_NV] = 1'b1;
        if (nan || !neg) begin
            res = is_unsigned ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
        end else begin
            res = is_unsigned ? 32'h0000_0000 : 32'h8000_0000;
        end
    end else begin
        res         = neg ? -mag[31:0] : mag[31:0];
        fl[FLAG_NX] = (rem != '0);
    end
endfunction

function automatic void int_to_float_expected(input logic [31:0] w, input logic is_unsigned,
                                              input rnd_mode_t rnd, output fp_operand_u res,
                                              output fp_flags_t fl);
    logic        neg;
    logic [32:0] mag, q, rem, half;
    int          p;
    neg = ~is_unsigned & w[31];
    mag = neg ? 33'h1_0000_0000 - {1'b0, w} : {1'b0, w};
    res = '0;
    fl  = '0;
    p   = 0;
    for (int i = 0; i < 33; i++) begin
        if (mag[i]) begin
            p = i;
        end
    end
    if (p <= 23) begin
        q    = mag << (23 - p);
        rem  = '0;
        half = 33'h1;
    end else begin
        q    = mag >> (p - 23);
        rem  = mag & ((33'h1 << (p - 23)) - 1);
        half = 33'h1 << (p - 24);
    end
    q = q + {32'h0, round_increment(rnd, neg, q[0], rem > half, rem == half, rem != '0)};
    if (q[24]) begin
        q = q >> 1;  // rounding carried into a new leading bit
        p = p + 1;
    end
    if (mag != '0) begin
        res.fp.sign     = neg;
        res.fp.exponent = 8'(127 + p);
        res.fp.fraction = q[22:0];
        fl[FLAG_NX]     = (rem != '0);
    end
endfunction

`endif

// ==== bench/fp_cvt_tb.sv ====
`timescale 1ns/100ps
`include "fp_cvt_params.svh"

module fp_cvt_tb
    import fp_wire::*;
();

    localparam int RESET_CYCLES    = 5;
    localparam int NUM_RANGE       = 300;
    localparam int NUM_SPECIAL     = 150;
    localparam int NUM_I2F         = 300;
    localparam int NUM_TIMING      = 20;
    localparam int NUM_STATUS      = 24;
    localparam int NUM_TESTS       = NUM_RANGE + NUM_SPECIAL + NUM_I2F + NUM_TIMING
                                   + NUM_STATUS + 5;  // the extra ones are status clears
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 10 + RESET_CYCLES;

    logic                         clock;
    logic                         rst;
    logic                         start;
    cvt_op_t                      op;
    rnd_mode_t                    rm;
    fp_operand_u                  operand;
    logic                         clear;
    logic                         busy;
    logic                         valid;
    fp_operand_u                  result;
    fp_flags_t                    flags;
    fp_flags_t                    acc_flags;
    logic [`FP_CVT_CNT_WIDTH-1:0] count;

    integer                       seed;
    string                        current_test;
    int                           error_count;
    int                           check_total;
    int                           test_errors;
    int                           test_runs;
    cvt_op_t                      last_op;
    rnd_mode_t                    last_rm;
    fp_operand_u                  last_operand;
    fp_flags_t                    model_acc;
    logic [`FP_CVT_CNT_WIDTH-1:0] model_count;

    `include "fp_cvt_model.svh"

    fp_cvt_unit fp_cvt_unit_i (
        .clock_i     (clock),
        .rst_i       (rst),
        .start_i     (start),
        .op_i        (op),
        .rm_i        (rm),
        .operand_i   (operand),
        .clear_i     (clear),
        .busy_o      (busy),
        .valid_o     (valid),
        .result_o    (result),
        .flags_o     (flags),
        .acc_flags_o (acc_flags),
        .count_o     (count)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, the conversions did not finish",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic int unsigned random_below(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic rnd_mode_t random_rounding();
        return rnd_mode_t'(3'(random_below(5)));
    endfunction

    // classes 0 to 3 stay mostly in range, 4 to 8 are limits and special encodings
    function automatic fp_operand_u draw_float(input int unsigned cls);
        fp_operand_u v;
        int unsigned k;
        v.word = random_word();
        k      = random_below(24);
        case (cls)
            0: v.fp.exponent = 8'(125 + random_below(31));
            1: v.fp.exponent = 8'(118 + random_below(10));
            2: begin
                v.fp.exponent = 8'(127 + k);
                v.fp.fraction = v.fp.fraction & (23'h7F_FFFF << (23 - k));
            end
            3: begin
                k             = k % 23;  // exact halfway between two integers
                v.fp.exponent = 8'(127 + k);
                v.fp.fraction = (v.fp.fraction & (23'h7F_FFFF << (23 - k))) | (23'h1 << (22 - k));
            end
            4: begin
                v.fp.exponent = 8'(155 + random_below(6));
                if (random_below(2) == 0) begin
                    v.fp.fraction = (random_below(2) == 0) ? 23'h0 : 23'h7F_FFFF;
                end
            end
            5: begin
                v.fp.exponent    = 8'hFF;
                v.fp.fraction[0] = 1'b1;
            end
            6: begin
                v.fp.exponent = 8'hFF;
                v.fp.fraction = '0;
            end
            7: v.word = {v.fp.sign, 31'h0};
            default: v.fp.exponent = 8'h00;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] draw_int();
        logic [31:0] w;
        w = random_word();
        case (random_below(5))
            0: w = w >> random_below(32);
            1: w = -(w >> random_below(32));
            2: begin
                case (random_below(4))
                    0:       w = 32'h0000_0000;
                    1:       w = 32'h8000_0000;
                    2:       w = 32'h7FFF_FFFF;
                    default: w = 32'hFFFF_FFFF;
                endcase
            end
            3: w = {1'b1, w[22:0], 8'h80} >> random_below(8);  // halfway cases
            default: w = random_word();
        endcase
        return w;
    endfunction

    function automatic fp_operand_u random_operand(input cvt_op_t sel_op);
        fp_operand_u v;
        if (sel_op[1]) begin
            v.word = draw_int();
        end else begin
            v = draw_float(random_below(9));
        end
        return v;
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s (op %0d rm %0d operand %08h)", current_test, what, last_op, last_rm,
                 last_operand.word);
        count_error();
    endtask

    task automatic check_result(input string what, input fp_operand_u expected,
                                input fp_operand_u actual);
        check_total++;
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %08h actual %08h (op %0d rm %0d operand %08h)",
                     current_test, what, expected.word, actual.word, last_op, last_rm,
                     last_operand.word);
            count_error();
        end
    endtask

    task automatic check_flags(input string what, input fp_flags_t expected,
                               input fp_flags_t actual);
        check_total++;
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %05b actual %05b (op %0d rm %0d operand %08h)",
                     current_test, what, expected, actual, last_op, last_rm, last_operand.word);
            count_error();
        end
    endtask

    task automatic check_count(input logic [`FP_CVT_CNT_WIDTH-1:0] expected,
                               input logic [`FP_CVT_CNT_WIDTH-1:0] actual);
        check_total++;
        if (actual !== expected) begin
            $display("[ERROR] %s count: expected %0d actual %0d", current_test, expected, actual);
            count_error();
        end
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
        test_runs    = 0;
    endtask

    task automatic end_test();
        $display("%s: %0d conversions, %0d errors", current_test, test_runs, test_errors);
    endtask

    // one request, optionally with a start or a clear in the busy cycle
    task automatic convert(input cvt_op_t sel_op, input rnd_mode_t sel_rm,
                           input fp_operand_u value, input logic poke_start,
                           input logic poke_clear);
        fp_operand_u exp_result;
        fp_flags_t   exp_flags;
        logic [31:0] int_word;
        int          cycles;
        last_op      = sel_op;
        last_rm      = sel_rm;
        last_operand = value;
        test_runs++;
        if (sel_op[1]) begin
            int_to_float_expected(value.word, sel_op[0], sel_rm, exp_result, exp_flags);
        end else begin
            float_to_int_expected(value, sel_op[0], sel_rm, int_word, exp_flags);
            exp_result.word = int_word;
        end
        @(negedge clock);
        start   = 1'b1;
        op      = sel_op;
        rm      = sel_rm;
        operand = value;
        cycles  = 0;
        do begin
            @(negedge clock);
            cycles++;
            start        = (cycles == 1) & poke_start;
            clear        = (cycles == 1) & poke_clear;
            operand.word = ~value.word;  // the request registers must hold the old word
            if (cycles == 1 && busy !== 1'b1) begin
                report_problem("busy_o is low in the cycle after the start");
            end
        end while (valid !== 1'b1 && cycles < 6);
        start = 1'b0;
        clear = 1'b0;
        if (valid !== 1'b1) begin
            report_problem("valid_o never rose after the start");
        end else begin
            if (cycles != 2) begin
                report_problem($sformatf("valid_o came %0d cycles after the start, not 2",
                                         cycles));
            end
            if (busy !== 1'b0) begin
                report_problem("busy_o is still high in the valid cycle");
            end
            if (poke_clear) begin
                model_acc   = '0;  // the clear wins over the completing flags
                model_count = 1;
            end else begin
                model_acc   = model_acc | exp_flags;
                model_count = model_count + 1'b1;
            end
            check_result("result", exp_result, result);
            check_flags("flags", exp_flags, flags);
            check_flags("acc_flags", model_acc, acc_flags);
            check_count(model_count, count);
        end
        @(negedge clock);
        if (valid !== 1'b0 || busy !== 1'b0) begin
            report_problem("valid_o or busy_o is high after the valid cycle");
        end
    endtask

    task automatic clear_status();
        @(negedge clock);
        clear = 1'b1;
        @(negedge clock);
        clear       = 1'b0;
        model_acc   = '0;
        model_count = '0;
        check_flags("acc_flags after clear", model_acc, acc_flags);
        check_count(model_count, count);
    endtask

    initial begin
        cvt_op_t     sel_op;
        rnd_mode_t   sel_rm;
        fp_operand_u value;
        seed         = 42;
        error_count  = 0;
        check_total  = 0;
        model_acc    = '0;
        model_count  = '0;
        last_op      = CVT_F2I;
        last_rm      = RM_RNE;
        last_operand = '0;
        rst          = 1'b1;
        start        = 1'b0;
        op           = CVT_F2I;
        rm           = RM_RNE;
        operand      = '0;
        clear        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        begin_test("reset");
        check_result("result", '0, result);
        check_flags("flags", '0, flags);
        check_flags("acc_flags", '0, acc_flags);
        check_count('0, count);
        if (busy !== 1'b0 || valid !== 1'b0) begin
            report_problem("busy_o or valid_o is high after reset");
        end
        end_test();

        begin_test("float_to_int_range");
        for (int i = 0; i < NUM_RANGE; i++) begin
            sel_op = cvt_op_t'({1'b0, 1'(random_below(2))});
            sel_rm = random_rounding();
            value  = draw_float(random_below(4));
            convert(sel_op, sel_rm, value, 1'b0, 1'b0);
        end
        end_test();

        begin_test("float_to_int_special");
        for (int i = 0; i < NUM_SPECIAL; i++) begin
            sel_op = cvt_op_t'({1'b0, 1'(random_below(2))});
            sel_rm = random_rounding();
            value  = draw_float(4 + random_below(5));
            convert(sel_op, sel_rm, value, 1'b0, 1'b0);
        end
        end_test();

        begin_test("int_to_float");
        for (int i = 0; i < NUM_I2F; i++) begin
            sel_op = cvt_op_t'({1'b1, 1'(random_below(2))});
            sel_rm = random_rounding();
            value  = random_operand(sel_op);
            convert(sel_op, sel_rm, value, 1'b0, 1'b0);
        end
        end_test();

        begin_test("timing");
        for (int i = 0; i < NUM_TIMING; i++) begin
            sel_op = cvt_op_t'(2'(random_below(4)));
            sel_rm = random_rounding();
            value  = random_operand(sel_op);
            convert(sel_op, sel_rm, value, 1'b1, 1'b0);
        end
        end_test();

        begin_test("status");
        clear_status();
        for (int i = 0; i < NUM_STATUS; i++) begin
            sel_op = cvt_op_t'(2'(random_below(4)));
            sel_rm = random_rounding();
            value  = random_operand(sel_op);
            convert(sel_op, sel_rm, value, 1'b0, i % 5 == 3);
            if (i % 8 == 7) begin
                clear_status();
            end
        end
        clear_status();
        end_test();

        $display("total: %0d checks, %0d errors", check_total, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
+incdir+bench
design/lzc_wire.sv
design/fp_wire.sv
design/lzc_32.sv
design/fp_cvt.sv
design/fp_rnd.sv
design/fp_cvt_ctrl.sv
design/fp_cvt_status.sv
design/fp_cvt_unit.sv
bench/fp_cvt_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the conversion unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f \
    --top-module fp_cvt_tb --Mdir obj_dir -o fp_cvt_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/fp_cvt_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
